// File: Makefile
TOP = tb_execute_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f execute_stage.f --top-module $(TOP)

# the run passes only if the pass line shows up in the simulation output
sim:
	verilator --binary --timing --assert -j 0 -f execute_stage.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: execute_stage.f
+incdir+logic
logic/rv_types_pkg.sv
logic/ex_ctrl_pkg.sv
logic/ex_stall_hold.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/ex_result_reg.sv
logic/execute_stage.sv
verif/execute_stage_assertions.sv
verif/tb_execute_stage.sv

// File: logic/alu_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module alu_unit (
	input  ex_ctrl_pkg::exe_fun_t exe_fun,
	input  rv_types_pkg::word_t   op1,
	input  rv_types_pkg::word_t   op2,
	output rv_types_pkg::word_t   result
);

	import rv_types_pkg::*;

	shamt_t shamt;
	word_t  sum;
	word_t  diff;
	logic   lt_s;
	logic   lt_u;

	assign shamt = op2[`SHAMT_W-1:0]; // upper bits of op2 are ignored.
	assign sum   = op1 + op2;
	assign diff  = op1 - op2;
	assign lt_s  = $signed(op1) < $signed(op2);
	assign lt_u  = op1 < op2;

	always_comb begin
		case (exe_fun)
			`ALU_ADD: begin
				result = sum;
			end
			`ALU_SUB: begin
				result = diff;
			end
			`ALU_AND: begin
				result = op1 & op2;
			end
			`ALU_OR: begin
				result = op1 | op2;
			end
			`ALU_XOR: begin
				result = op1 ^ op2;
			end
			`ALU_SLL: begin
				result = op1 << shamt;
			end
			`ALU_SRL: begin
				result = op1 >> shamt;
			end
			`ALU_SRA: begin
				result = word_t'($signed(op1) >>> shamt);
			end
			`ALU_SLT: begin
				result = word_t'(lt_s);
			end
			`ALU_SLTU: begin
				result = word_t'(lt_u);
			end
			`ALU_JALR: begin
				result = sum & ~word_t'(1);
			end
			`ALU_COPY1: begin
				result = op1;
			end
			default: begin
				result = '0; // ALU_X and all branch codes.
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/branch_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module branch_unit (
	input  ex_ctrl_pkg::exe_fun_t exe_fun,
	input  rv_types_pkg::word_t   op1,
	input  rv_types_pkg::word_t   op2,
	input  rv_types_pkg::pc_t     pc,
	input  rv_types_pkg::word_t   imm_b,
	output logic                  taken,
	output rv_types_pkg::pc_t     target
);

	logic eq;
	logic lt_s;
	logic lt_u;

	assign eq   = op1 == op2;
	assign lt_s = $signed(op1) < $signed(op2);
	assign lt_u = op1 < op2;

	// computed for every instruction, only used when taken.
	assign target = pc + imm_b;

	always_comb begin
		case (exe_fun)
			`BR_BEQ: begin
				taken = eq;
			end
			`BR_BNE: begin
				taken = !eq;
			end
			`BR_BLT: begin
				taken = lt_s;
			end
			`BR_BGE: begin
				taken = !lt_s;
			end
			`BR_BLTU: begin
				taken = lt_u;
			end
			`BR_BGEU: begin
				taken = !lt_u;
			end
			default: begin
				taken = 1'b0; // alu ops never branch.
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/ex_ctrl_pkg.sv
`default_nettype none

`include "rv_consts.svh"

package ex_ctrl_pkg;

	import rv_types_pkg::*;

	typedef logic [`EXE_FUN_W-1:0] exe_fun_t; // alu or branch code.
	typedef logic [4:0]            mem_wen_t; // zero means no store.
	typedef logic [3:0]            wb_sel_t;
	typedef logic [2:0]            csr_cmd_t;

	// decoded instruction as handed over by decode.
	typedef struct packed {
		pc_t      pc;
		exe_fun_t exe_fun;
		word_t    op1;
		word_t    op2;
		word_t    rs2_data;
		mem_wen_t mem_wen;
		wb_sel_t  wb_sel;
		csr_cmd_t csr_cmd;
		word_t    imm_i;
		word_t    imm_b;
	} ex_in_t;

	// registered result towards the memory stage.
	typedef struct packed {
		word_t    alu_out;
		logic     br_flg;
		pc_t      br_target;
		pc_t      pc;
		mem_wen_t mem_wen;
		wb_sel_t  wb_sel;
		word_t    rs2_data;
		word_t    op1_data;
		csr_cmd_t csr_cmd;
		word_t    imm_i;
	} ex_out_t;

endpackage

`default_nettype wire

// File: logic/ex_result_reg.sv
`default_nettype none
`timescale 1ns/100ps

module ex_result_reg (
	input  logic                clk,
	input  logic                rst_n,
	input  ex_ctrl_pkg::ex_in_t  cur,
	input  rv_types_pkg::word_t alu_result,
	input  logic                taken,
	input  rv_types_pkg::pc_t   target,
	output ex_ctrl_pkg::ex_out_t ex
);

	import ex_ctrl_pkg::*;

	ex_out_t ex_next;

	// gather the unit results and the side-band fields.
	always_comb begin
		ex_next           = '0;
		ex_next.alu_out   = alu_result;
		ex_next.br_flg    = taken;
		ex_next.br_target = target;
		ex_next.pc        = cur.pc;
		ex_next.mem_wen   = cur.mem_wen;
		ex_next.wb_sel    = cur.wb_sel;
		ex_next.rs2_data  = cur.rs2_data; // store data.
		ex_next.op1_data  = cur.op1;      // csr source.
		ex_next.csr_cmd   = cur.csr_cmd;
		ex_next.imm_i     = cur.imm_i;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex <= '0; // no branch and no store out of reset.
		end else begin
			ex <= ex_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/ex_stall_hold.sv
`default_nettype none
`timescale 1ns/100ps

module ex_stall_hold (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               stall,
	input  ex_ctrl_pkg::ex_in_t dec,
	output ex_ctrl_pkg::ex_in_t cur
);

	import ex_ctrl_pkg::*;

	// bundle that was in the stage on the last edge.
	ex_in_t saved;

	// while frozen the old instruction runs again, new input is ignored.
	always_comb begin
		if (stall) begin
			cur = saved;
		end else begin
			cur = dec;
		end
	end

	// cur is stored every cycle, so a long stall keeps the same copy.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			saved <= '0; // stall right after reset gives a zero bundle.
		end else begin
			saved <= cur;
		end
	end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`default_nettype none
`timescale 1ns/100ps

module execute_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,
	input  ex_ctrl_pkg::ex_in_t  dec,
	output ex_ctrl_pkg::ex_out_t ex
);

	import rv_types_pkg::*;
	import ex_ctrl_pkg::*;

	ex_in_t cur;        // instruction executed this cycle.
	word_t  alu_result;
	logic   taken;
	pc_t    target;

	ex_stall_hold u_hold (
		.clk   (clk),
		.rst_n (rst_n),
		.stall (stall),
		.dec   (dec),
		.cur   (cur)
	);

	alu_unit u_alu (
		.exe_fun (cur.exe_fun),
		.op1     (cur.op1),
		.op2     (cur.op2),
		.result  (alu_result)
	);

	branch_unit u_branch (
		.exe_fun (cur.exe_fun),
		.op1     (cur.op1),
		.op2     (cur.op2),
		.pc      (cur.pc),
		.imm_b   (cur.imm_b),
		.taken   (taken),
		.target  (target)
	);

	// the only register stage between dec and ex.
	ex_result_reg u_result (
		.clk        (clk),
		.rst_n      (rst_n),
		.cur        (cur),
		.alu_result (alu_result),
		.taken      (taken),
		.target     (target),
		.ex         (ex)
	);

endmodule

`default_nettype wire

// File: logic/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath widths.
`define XLEN        32
`define SHAMT_W     5
`define EXE_FUN_W   5

// alu function codes.
`define ALU_X       5'd0  // no operation, result is zero.
`define ALU_ADD     5'd1
`define ALU_SUB     5'd2
`define ALU_AND     5'd3
`define ALU_OR      5'd4
`define ALU_XOR     5'd5
`define ALU_SLL     5'd6
`define ALU_SRL     5'd7
`define ALU_SRA     5'd8
`define ALU_SLT     5'd9
`define ALU_SLTU    5'd10
`define ALU_JALR    5'd11 // op1 + op2 with bit 0 cleared.
`define ALU_COPY1   5'd12

// branch function codes share the same field as the alu codes.
`define BR_BEQ      5'd13
`define BR_BNE      5'd14
`define BR_BLT      5'd15
`define BR_BGE      5'd16
`define BR_BLTU     5'd17
`define BR_BGEU     5'd18

`endif

// File: logic/rv_types_pkg.sv
`default_nettype none

`include "rv_consts.svh"

package rv_types_pkg;

	// one architectural data word.
	typedef logic [`XLEN-1:0] word_t;

	// instruction address.
	typedef logic [`XLEN-1:0] pc_t;

	// shift amount, taken from the low bits of op2.
	typedef logic [`SHAMT_W-1:0] shamt_t;

endpackage

`default_nettype wire

// File: verif/execute_cases.txt
# name stall exe_fun pc op1 op2 rs2 imm_i imm_b mem_wen wb_sel csr_cmd alu_out br_flg br_target
# all hex; the last three columns are expected, a stall line repeats the last non-stall result
01 1 01 00000100 00000005 00000007 11111111 00000004 00000008 01 1 1 00000000 0 00000000
10 0 01 00000200 7fffffff 00000001 deadbeef 00000010 00000020 00 1 0 80000000 0 00000220
11 0 01 00000204 ffffffff 00000002 00000000 fffff800 00000004 00 1 0 00000001 0 00000208
12 0 02 00000208 00000003 00000005 01234567 00000001 00000000 00 2 0 fffffffe 0 00000208
13 0 02 0000020c 80000000 00000001 89abcdef 000007ff 00000000 00 2 0 7fffffff 0 0000020c
14 0 03 00000210 f0f0f0f0 ff00ff00 0000aaaa 00000002 00000000 01 1 1 f000f000 0 00000210
15 0 04 00000214 f0f0f0f0 0f0f0000 0000bbbb 00000003 00000000 02 1 2 fffff0f0 0 00000214
16 0 05 00000218 aaaa5555 ffff0000 0000cccc 00000004 00000000 03 1 3 55555555 0 00000218
17 0 0c 0000021c 12345678 9abcdef0 0000dddd 00000005 00000000 00 4 0 12345678 0 0000021c
18 0 0b 00000220 00001001 00000002 00000000 00000002 00000000 00 3 0 00001002 0 00000220
19 0 0b 00000224 00000ffe 00000003 00000000 00000003 00000000 00 3 0 00001000 0 00000224
20 0 06 00000228 00000001 0000001f 10000000 00000006 00000000 00 1 0 80000000 0 00000228
21 0 06 0000022c 0000000f 00000024 20000000 00000007 00000000 00 1 0 000000f0 0 0000022c
22 0 07 00000230 80000000 00000004 30000000 00000008 00000000 00 1 0 08000000 0 00000230
23 0 08 00000234 80000000 00000004 40000000 00000009 00000000 00 1 0 f8000000 0 00000234
24 0 08 00000238 fffffff0 00000022 50000000 0000000a 00000000 00 1 0 fffffffc 0 00000238
25 0 09 0000023c ffffffff 00000001 60000000 0000000b 00000000 00 1 0 00000001 0 0000023c
26 0 0a 00000240 ffffffff 00000001 70000000 0000000c 00000000 00 1 0 00000000 0 00000240
27 0 09 00000244 00000001 ffffffff 80000000 0000000d 00000000 00 1 0 00000000 0 00000244
28 0 0a 00000248 00000001 ffffffff 90000000 0000000e 00000000 00 1 0 00000001 0 00000248
30 0 0d 00000300 00000005 00000005 00000000 00000000 00000010 00 0 0 00000000 1 00000310
31 0 0d 00000300 00000005 00000006 00000000 00000000 fffffff0 00 0 0 00000000 0 000002f0
32 0 0e 00000304 00000005 00000006 00000000 00000000 00000008 00 0 0 00000000 1 0000030c
33 0 0e 00000304 00000007 00000007 00000000 00000000 00000008 00 0 0 00000000 0 0000030c
34 0 0f 00000308 ffffffff 00000001 00000000 00000000 fffffff8 00 0 0 00000000 1 00000300
35 0 0f 00000308 00000001 ffffffff 00000000 00000000 00000008 00 0 0 00000000 0 00000310
36 0 10 0000030c 00000001 ffffffff 00000000 00000000 00000004 00 0 0 00000000 1 00000310
37 0 10 0000030c ffffffff 00000001 00000000 00000000 00000004 00 0 0 00000000 0 00000310
38 0 11 00000310 00000001 ffffffff 00000000 00000000 00000100 00 0 0 00000000 1 00000410
39 0 11 00000310 ffffffff 00000001 00000000 00000000 00000100 00 0 0 00000000 0 00000410
3a 0 12 00000314 ffffffff 00000001 00000000 00000000 ffffff00 00 0 0 00000000 1 00000214
3b 0 12 00000314 00000001 ffffffff 00000000 00000000 ffffff00 00 0 0 00000000 0 00000214
3c 0 00 00000318 00000005 00000005 00000000 00000000 00000004 00 0 0 00000000 0 0000031c
40 0 01 00000400 00000010 00000020 cafef00d 00000abc 00000040 1f 5 3 00000030 0 00000440
41 1 02 00000500 00000099 00000001 11112222 00000123 00000008 02 6 4 00000030 0 00000440
42 1 0d 00000504 00000007 00000007 33334444 00000456 00000010 03 7 5 00000030 0 00000440
43 1 0c 00000508 87654321 00000000 55556666 00000789 00000000 04 8 6 00000030 0 00000440
44 0 0d 00000600 00000003 00000003 77778888 00000def 00000020 00 9 7 00000000 1 00000620
45 0 0c 00000604 abcdef01 00000000 9999aaaa 00000fed 00000000 08 a 2 abcdef01 0 00000604

// File: verif/execute_stage_assertions.sv
`default_nettype none
`timescale 1ns/100ps

module execute_stage_assertions (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 stall,
	input ex_ctrl_pkg::ex_in_t  cur,
	input ex_ctrl_pkg::ex_out_t ex
);

	property p_reset_clears;
		@(posedge clk) !rst_n |=> ex == '0; // whole bundle, not just the flags.
	endproperty

	// a frozen stage runs the saved bundle again.
	property p_stall_holds;
		@(posedge clk) disable iff (!rst_n) stall |=> $stable(ex);
	endproperty

	property p_pc_follows;
		@(posedge clk) disable iff (!rst_n) rst_n |=> ex.pc == $past(cur.pc);
	endproperty

	a_reset_clears: assert property (p_reset_clears)
		else $error("ex is not zero after a cycle in reset");
	a_stall_holds: assert property (p_stall_holds)
		else $error("ex changed on an edge with stall high");
	a_pc_follows: assert property (p_pc_follows)
		else $error("ex.pc does not match the pc executed on the previous edge");

endmodule

bind execute_stage execute_stage_assertions u_sva (
	.clk   (clk),
	.rst_n (rst_n),
	.stall (stall),
	.cur   (cur),
	.ex    (ex)
);

`default_nettype wire

// File: verif/tb_execute_stage.sv
`default_nettype none
`timescale 1ns/100ps

module tb_execute_stage;

	import rv_types_pkg::*;
	import ex_ctrl_pkg::*;

	localparam int RESET_CYCLES = 3;

	logic    clk = 1'b0;
	logic    rst_n = 1'b0;
	logic    stall = 1'b0;
	ex_in_t  dec = '0;
	ex_out_t ex;

	// one entry per case line of the file.
	logic [7:0] case_name[$];
	logic       case_stall[$];
	ex_in_t     case_in[$];
	word_t      exp_alu[$];
	logic       exp_br[$];
	pc_t        exp_target[$];

	ex_in_t     last_run = '0; // bundle of the last non-stall case.
	logic [7:0] cur_name;
	int         cycles = 0;
	int         limit = 0;

	execute_stage uut (
		.clk   (clk),
		.rst_n (rst_n),
		.stall (stall),
		.dec   (dec),
		.ex    (ex)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic load_cases();
		int         fd;
		int         n;
		string      line;
		logic [7:0] name;
		logic       stl;
		exe_fun_t   fun;
		pc_t        pc;
		word_t      op1;
		word_t      op2;
		word_t      rs2;
		word_t      imm_i;
		word_t      imm_b;
		mem_wen_t   mw;
		wb_sel_t    ws;
		csr_cmd_t   cc;
		word_t      alu;
		logic       br;
		pc_t        tgt;
		ex_in_t     b;
		fd = $fopen("verif/execute_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/execute_cases.txt");
			$display("RESULT: FAIL");
			$fatal(1, "missing cases file");
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					name, stl, fun, pc, op1, op2, rs2, imm_i, imm_b,
					mw, ws, cc, alu, br, tgt);
				if (n == 15) begin // comment lines give no fields.
					b          = '0;
					b.pc       = pc;
					b.exe_fun  = fun;
					b.op1      = op1;
					b.op2      = op2;
					b.rs2_data = rs2;
					b.mem_wen  = mw;
					b.wb_sel   = ws;
					b.csr_cmd  = cc;
					b.imm_i    = imm_i;
					b.imm_b    = imm_b;
					case_name.push_back(name);
					case_stall.push_back(stl);
					case_in.push_back(b);
					exp_alu.push_back(alu);
					exp_br.push_back(br);
					exp_target.push_back(tgt);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR case %h %s: expected %h, actual %h", cur_name, what, expected,
				actual);
			$display("RESULT: FAIL");
			$fatal(1, "first mismatch");
		end
	endtask

	task automatic check_reset();
		cur_name = 8'h00;
		check_value("alu_out", 32'h0, ex.alu_out);
		check_value("br_flg", 32'h0, 32'(ex.br_flg));
		check_value("mem_wen", 32'h0, 32'(ex.mem_wen));
	endtask

	task automatic check_case(input int i);
		ex_in_t ref_in;
		if (case_stall[i]) begin
			ref_in = last_run; // frozen stage keeps the older instruction.
		end else begin
			ref_in   = case_in[i];
			last_run = case_in[i];
		end
		cur_name = case_name[i];
		check_value("alu_out", exp_alu[i], ex.alu_out);
		check_value("br_flg", 32'(exp_br[i]), 32'(ex.br_flg));
		check_value("br_target", exp_target[i], ex.br_target);
		check_value("pc", ref_in.pc, ex.pc);
		check_value("mem_wen", 32'(ref_in.mem_wen), 32'(ex.mem_wen));
		check_value("wb_sel", 32'(ref_in.wb_sel), 32'(ex.wb_sel));
		check_value("csr_cmd", 32'(ref_in.csr_cmd), 32'(ex.csr_cmd));
		check_value("rs2_data", ref_in.rs2_data, ex.rs2_data);
		check_value("op1_data", ref_in.op1, ex.op1_data);
		check_value("imm_i", ref_in.imm_i, ex.imm_i);
	endtask

	initial begin
		load_cases();
		limit = case_name.size() + RESET_CYCLES + 20;
		@(posedge clk);
		#1;
		check_reset(); // still inside reset.
		repeat (RESET_CYCLES - 1) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_reset();
		for (int i = 0; i < case_name.size(); i++) begin
			stall = case_stall[i];
			dec   = case_in[i];
			@(posedge clk);
			#1;
			check_case(i);
		end
		if (case_name.size() == 0) begin
			$display("no cases were read from the cases file");
			$display("RESULT: FAIL");
			$fatal(1, "empty cases file");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
